/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_id_stage
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
src/la_decode_pkg.sv
src/inst_decoder.sv
src/operand_bypass.sv
src/branch_unit.sv
src/regfile.sv
src/id_stage.sv
tests/tb_clock.sv
tests/tb_id_stage.sv

/* src/branch_unit.sv */
module branch_unit import la_decode_pkg::*; (
    input  br_kind_t kind,
    input  word_t    pc,
    input  word_t    rj_value,
    input  word_t    rkd_value,
    input  word_t    br_offs,
    input  word_t    jirl_offs,
    output logic     cond_taken,
    output word_t    target
);

    logic eq;
    logic ge_s;
    logic ge_u;

    assign eq   = (rj_value == rkd_value);
    assign ge_s = $signed(rj_value) >= $signed(rkd_value);
    assign ge_u = rj_value >= rkd_value;

    assign cond_taken = (kind.beq  &  eq)
                      | (kind.bne  & ~eq)
                      | (kind.blt  & ~ge_s)
                      | (kind.bge  &  ge_s)
                      | (kind.bltu & ~ge_u)
                      | (kind.bgeu &  ge_u)
                      | kind.b
                      | kind.bl
                      | kind.jirl;

    // jirl is register relative and everything else pc relative
    assign target = kind.jirl ? (rj_value + jirl_offs) : (pc + br_offs);

endmodule

/* src/id_stage.sv */
module id_stage import la_decode_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      fs_to_ds_valid,
    input  f2d_t      fs_to_ds_bus,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output d2e_t      ds_to_es_bus,
    input  exe_fwd_t  es_fwd,
    input  rf_write_t ms_fwd,
    input  rf_write_t ws_write,
    output br_req_t   br
);

    logic         ds_valid;
    f2d_t         ds_bus;
    decode_ctrl_t ctrl;
    word_t        rf_rdata1;
    word_t        rf_rdata2;
    word_t        rj_value;
    word_t        rkd_value;
    word_t        br_target;
    logic         load_use_stall;
    logic         stall;
    logic         cond_taken;
    logic         leave;
    logic         br_taken;

    // stall only means something for a valid instruction
    assign stall          = ds_valid & load_use_stall;
    assign ds_to_es_valid = ds_valid & ~stall;
    assign ds_allowin     = ~ds_valid | (~stall & es_allowin);
    assign leave          = ds_to_es_valid & es_allowin;
    assign br_taken       = cond_taken & leave;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            // wrong-path fetch is dropped
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    inst_decoder u_decoder (
        .inst (ds_bus.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (ctrl.raddr2),
        .rdata2 (rf_rdata2),
        .wr     (ws_write)
    );

    operand_bypass u_bypass (
        .raddr1         (ctrl.raddr1),
        .raddr2         (ctrl.raddr2),
        .need_r1        (ctrl.need_r1),
        .need_r2        (ctrl.need_r2),
        .rdata1         (rf_rdata1),
        .rdata2         (rf_rdata2),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_write       (ws_write),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch (
        .kind       (ctrl.br_kind),
        .pc         (ds_bus.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .br_offs    (ctrl.br_offs),
        .jirl_offs  (ctrl.br_offs),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    always_comb begin
        ds_to_es_bus.alu_op       = ctrl.alu_op;
        ds_to_es_bus.alu_src1     = ctrl.src1_is_pc ? ds_bus.pc : rj_value;
        ds_to_es_bus.alu_src2     = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        ds_to_es_bus.res_from_mem = ctrl.mem_op.ld_w | ctrl.mem_op.ld_h | ctrl.mem_op.ld_hu
                                  | ctrl.mem_op.ld_b | ctrl.mem_op.ld_bu;
        ds_to_es_bus.mem_op       = ctrl.mem_op;
        ds_to_es_bus.mem_en       = (ctrl.mem_op.st_w | ctrl.mem_op.st_h | ctrl.mem_op.st_b)
                                  & ds_valid;
        ds_to_es_bus.rf_we        = ctrl.rf_we;
        ds_to_es_bus.rf_waddr     = ctrl.dest;
        // store data comes from rd
        ds_to_es_bus.rkd_value    = rkd_value;
        ds_to_es_bus.pc           = ds_bus.pc;
    end

    always_comb begin
        br.stall  = stall & (|ctrl.br_kind);
        br.taken  = br_taken;
        br.target = br_target;
    end

endmodule

/* src/inst_decoder.sv */
module inst_decoder import la_decode_pkg::*; (
    input  inst_u        inst,
    output decode_ctrl_t ctrl
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic grp_3r;
    logic grp_shi;
    logic grp_ri;
    logic grp_mem;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui;
    logic inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;

    mem_op_t  mem_op;
    br_kind_t kind;
    alu_op_t  alu_op;
    logic     is_ld;
    logic     is_st;
    logic     is_cond_br;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     need_ui5;
    logic     need_si12;
    logic     need_ui12;
    logic     need_si20;
    logic     need_si26;
    logic     src2_is_4;

    assign op6 = inst.fmt_3r.op6;
    assign op4 = inst.fmt_3r.op4;
    assign op2 = inst.fmt_3r.op2;
    assign op5 = inst.fmt_3r.op5;
    assign i12 = inst.fmt_2ri12.i12;
    assign i16 = inst.fmt_2ri16.i16;
    assign i20 = inst.fmt_1ri20.i20;
    assign i26 = {inst.fmt_i26.offs_hi, inst.fmt_i26.offs_lo};

    assign grp_3r  = (op6 == op6_alu) && (op4 == op4_3r) && (op2 == op2_3r);
    assign grp_shi = (op6 == op6_alu) && (op4 == op4_shi) && (op2 == op2_shi);
    assign grp_ri  = (op6 == op6_alu);
    assign grp_mem = (op6 == op6_mem);

    assign inst_add_w  = grp_3r && (op5 == op5_add);
    assign inst_sub_w  = grp_3r && (op5 == op5_sub);
    assign inst_slt    = grp_3r && (op5 == op5_slt);
    assign inst_sltu   = grp_3r && (op5 == op5_sltu);
    assign inst_nor    = grp_3r && (op5 == op5_nor);
    assign inst_and    = grp_3r && (op5 == op5_and);
    assign inst_or     = grp_3r && (op5 == op5_or);
    assign inst_xor    = grp_3r && (op5 == op5_xor);
    assign inst_sll_w  = grp_3r && (op5 == op5_sll);
    assign inst_srl_w  = grp_3r && (op5 == op5_srl);
    assign inst_sra_w  = grp_3r && (op5 == op5_sra);
    assign inst_slli_w = grp_shi && (op5 == op5_slli);
    assign inst_srli_w = grp_shi && (op5 == op5_srli);
    assign inst_srai_w = grp_shi && (op5 == op5_srai);

    assign inst_addi_w = grp_ri && (op4 == op4_addi);
    assign inst_slti   = grp_ri && (op4 == op4_slti);
    assign inst_sltui  = grp_ri && (op4 == op4_sltui);
    assign inst_andi   = grp_ri && (op4 == op4_andi);
    assign inst_ori    = grp_ri && (op4 == op4_ori);
    assign inst_xori   = grp_ri && (op4 == op4_xori);

    // inst[25] must be zero for the 20-bit immediate forms
    assign inst_lu12i_w   = inst.fmt_1ri20.opc == {op6_lu12i, 1'b0};
    assign inst_pcaddu12i = inst.fmt_1ri20.opc == {op6_pcaddu12i, 1'b0};

    assign mem_op.ld_b  = grp_mem && (op4 == op4_ld_b);
    assign mem_op.ld_h  = grp_mem && (op4 == op4_ld_h);
    assign mem_op.ld_w  = grp_mem && (op4 == op4_ld_w);
    assign mem_op.ld_bu = grp_mem && (op4 == op4_ld_bu);
    assign mem_op.ld_hu = grp_mem && (op4 == op4_ld_hu);
    assign mem_op.st_b  = grp_mem && (op4 == op4_st_b);
    assign mem_op.st_h  = grp_mem && (op4 == op4_st_h);
    assign mem_op.st_w  = grp_mem && (op4 == op4_st_w);

    assign kind.beq  = (op6 == op6_beq);
    assign kind.bne  = (op6 == op6_bne);
    assign kind.blt  = (op6 == op6_blt);
    assign kind.bge  = (op6 == op6_bge);
    assign kind.bltu = (op6 == op6_bltu);
    assign kind.bgeu = (op6 == op6_bgeu);
    assign kind.b    = (op6 == op6_b);
    assign kind.bl   = (op6 == op6_bl);
    assign kind.jirl = (op6 == op6_jirl);

    assign is_ld = mem_op.ld_w | mem_op.ld_h | mem_op.ld_hu | mem_op.ld_b | mem_op.ld_bu;
    assign is_st = mem_op.st_w | mem_op.st_h | mem_op.st_b;
    assign is_cond_br = kind.beq | kind.bne | kind.blt | kind.bge | kind.bltu | kind.bgeu;

    // address generation and link value both go through the adder
    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | is_ld | is_st
                            | kind.jirl | kind.bl | inst_pcaddu12i;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt | inst_slti;
    assign alu_op[alu_sltu] = inst_sltu | inst_sltui;
    assign alu_op[alu_and]  = inst_and | inst_andi;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or | inst_ori;
    assign alu_op[alu_xor]  = inst_xor | inst_xori;
    assign alu_op[alu_sll]  = inst_sll_w | inst_slli_w;
    assign alu_op[alu_srl]  = inst_srl_w | inst_srli_w;
    assign alu_op[alu_sra]  = inst_sra_w | inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | is_ld | is_st | inst_slti | inst_sltui;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_si26 = kind.b | kind.bl;
    assign src2_is_4 = kind.jirl | kind.bl;

    assign src1_is_pc  = kind.jirl | kind.bl | inst_pcaddu12i;
    assign src2_is_imm = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;

    always_comb begin
        ctrl.alu_op      = alu_op;
        ctrl.mem_op      = mem_op;
        ctrl.br_kind     = kind;
        ctrl.src1_is_pc  = src1_is_pc;
        ctrl.src2_is_imm = src2_is_imm;
        // jirl reads rj for its target even though src1 is the pc
        ctrl.need_r1     = ((|alu_op) & ~src1_is_pc & ~inst_lu12i_w) | is_cond_br | kind.jirl;
        ctrl.need_r2     = ((|alu_op) & ~src2_is_imm) | is_cond_br | is_st;
        ctrl.rf_we       = (|alu_op) & ~is_st;
        ctrl.dest        = kind.bl ? reg_addr_t'(1) : inst.fmt_3r.rd;
        ctrl.raddr1      = inst.fmt_3r.rj;
        ctrl.raddr2      = (is_st | is_cond_br) ? inst.fmt_3r.rd : inst.fmt_3r.rk;

        if (src2_is_4) begin
            ctrl.imm = word_t'(4);
        end else if (need_si20) begin
            ctrl.imm = {i20, 12'b0};
        end else if (need_si12) begin
            ctrl.imm = {{20{i12[11]}}, i12};
        end else if (need_ui5) begin
            ctrl.imm = {27'b0, inst.fmt_3r.rk};
        end else if (need_ui12) begin
            ctrl.imm = {20'b0, i12};
        end else begin
            ctrl.imm = '0;
        end

        if (need_si26) begin
            ctrl.br_offs = {{4{i26[25]}}, i26, 2'b0};
        end else begin
            ctrl.br_offs = {{14{i16[15]}}, i16, 2'b0};
        end
    end

endmodule

/* src/la_decode_pkg.sv */
package la_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [alu_op_w-1:0]   alu_op_t;

    // major opcode in inst[31:26]
    localparam logic [5:0] op6_alu       = 6'h00;
    localparam logic [5:0] op6_lu12i     = 6'h05;
    localparam logic [5:0] op6_pcaddu12i = 6'h07;
    localparam logic [5:0] op6_mem       = 6'h0a;
    localparam logic [5:0] op6_jirl      = 6'h13;
    localparam logic [5:0] op6_b         = 6'h14;
    localparam logic [5:0] op6_bl        = 6'h15;
    localparam logic [5:0] op6_beq       = 6'h16;
    localparam logic [5:0] op6_bne       = 6'h17;
    localparam logic [5:0] op6_blt       = 6'h18;
    localparam logic [5:0] op6_bge       = 6'h19;
    localparam logic [5:0] op6_bltu      = 6'h1a;
    localparam logic [5:0] op6_bgeu      = 6'h1b;

    // meaning of inst[25:22] depends on op6
    localparam logic [3:0] op4_3r    = 4'h0;
    localparam logic [3:0] op4_shi   = 4'h1;
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;
    localparam logic [3:0] op4_ld_b  = 4'h0;
    localparam logic [3:0] op4_ld_h  = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_b  = 4'h4;
    localparam logic [3:0] op4_st_h  = 4'h5;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_ld_bu = 4'h8;
    localparam logic [3:0] op4_ld_hu = 4'h9;

    localparam logic [1:0] op2_shi = 2'h0;
    localparam logic [1:0] op2_3r  = 2'h1;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

    // one-hot alu_op bit positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef union packed {
        struct packed {
            logic [5:0] op6;
            logic [3:0] op4;
            logic [1:0] op2;
            logic [4:0] op5;
            reg_addr_t  rk;
            reg_addr_t  rj;
            reg_addr_t  rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opc;
            logic [11:0] i12;
            reg_addr_t   rj;
            reg_addr_t   rd;
        } fmt_2ri12;
        struct packed {
            logic [5:0]  opc;
            logic [15:0] i16;
            reg_addr_t   rj;
            reg_addr_t   rd;
        } fmt_2ri16;
        struct packed {
            logic [6:0]  opc;
            logic [19:0] i20;
            reg_addr_t   rd;
        } fmt_1ri20;
        // offs_hi holds i26[25:16]
        struct packed {
            logic [5:0]  opc;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } fmt_i26;
    } inst_u;

    typedef struct packed {
        logic ld_w;
        logic ld_h;
        logic ld_hu;
        logic ld_b;
        logic ld_bu;
        logic st_w;
        logic st_h;
        logic st_b;
    } mem_op_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic b;
        logic bl;
        logic jirl;
    } br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        br_kind_t  br_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      need_r1;
        logic      need_r2;
        logic      rf_we;
        reg_addr_t dest;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        word_t     imm;
        word_t     br_offs;
    } decode_ctrl_t;

    typedef struct packed {
        word_t pc;
        inst_u inst;
    } f2d_t;

    typedef struct packed {
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        logic      res_from_mem;
        mem_op_t   mem_op;
        logic      mem_en;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rkd_value;
        word_t     pc;
    } d2e_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic      res_from_mem;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } exe_fwd_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        word_t target;
    } br_req_t;

endpackage

/* src/operand_bypass.sv */
module operand_bypass import la_decode_pkg::*; (
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      need_r1,
    input  logic      need_r2,
    input  word_t     rdata1,
    input  word_t     rdata2,
    input  exe_fwd_t  es_fwd,
    input  rf_write_t ms_fwd,
    input  rf_write_t ws_write,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      load_use_stall
);

    logic es_hit1;
    logic es_hit2;
    logic ms_hit1;
    logic ms_hit2;
    logic ws_hit1;
    logic ws_hit2;

    // r0 never matches since it reads as zero from the regfile
    function automatic logic dest_hit(input reg_addr_t src, input logic we,
                                      input reg_addr_t waddr);
        return we && (src != '0) && (src == waddr);
    endfunction

    assign es_hit1 = dest_hit(raddr1, es_fwd.we, es_fwd.waddr);
    assign es_hit2 = dest_hit(raddr2, es_fwd.we, es_fwd.waddr);
    assign ms_hit1 = dest_hit(raddr1, ms_fwd.we, ms_fwd.waddr);
    assign ms_hit2 = dest_hit(raddr2, ms_fwd.we, ms_fwd.waddr);
    assign ws_hit1 = dest_hit(raddr1, ws_write.we, ws_write.waddr);
    assign ws_hit2 = dest_hit(raddr2, ws_write.we, ws_write.waddr);

    // youngest producer wins
    assign rj_value  = es_hit1 ? es_fwd.wdata   :
                       ms_hit1 ? ms_fwd.wdata   :
                       ws_hit1 ? ws_write.wdata :
                       rdata1;

    assign rkd_value = es_hit2 ? es_fwd.wdata   :
                       ms_hit2 ? ms_fwd.wdata   :
                       ws_hit2 ? ws_write.wdata :
                       rdata2;

    // load data not ready until mem stage
    assign load_use_stall = es_fwd.res_from_mem & ((es_hit1 & need_r1) | (es_hit2 & need_r2));

endmodule

/* src/regfile.sv */
module regfile import la_decode_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  rf_write_t wr
);

    // r0 has no storage
    word_t rf [1:31];

    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // bypass covers the old value read during a same-cycle write
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* tests/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic resetn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk    = 1'b0;
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
    end

    always #4 clk = ~clk;

endmodule

/* tests/tb_id_stage.sv */
module tb_id_stage import la_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_trans    = 3000;
    localparam int max_cycles = 4 * n_trans;

    typedef struct packed {
        alu_op_t   alu;
        mem_op_t   mem;
        br_kind_t  kind;
        logic      src1_pc;
        logic      src2_imm;
        logic      need1;
        logic      need2;
        logic      rf_we;
        reg_addr_t dest;
        reg_addr_t r1;
        reg_addr_t r2;
        word_t     imm;
        word_t     offs;
    } exp_dec_t;

    logic      clk;
    logic      resetn;
    logic      fs_valid;
    f2d_t      fs_bus;
    logic      ds_allowin;
    logic      es_allowin;
    logic      to_es_valid;
    d2e_t      to_es_bus;
    exe_fwd_t  es_fwd;
    rf_write_t ms_fwd;
    rf_write_t ws_write;
    br_req_t   br;

    word_t     shadow [32];
    logic      m_valid;
    word_t     m_pc;
    word_t     m_inst;
    int        emitted;
    int        cycles;

    logic [4:0] op5_3r [0:10] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                  5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    logic [4:0] op5_sh [0:2]  = '{5'h01, 5'h09, 5'h11};
    logic [3:0] op4_ri [0:5]  = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    logic [3:0] op4_mem [0:7] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9};

    tb_clock u_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    id_stage u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_valid),
        .fs_to_ds_bus   (fs_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (to_es_valid),
        .ds_to_es_bus   (to_es_bus),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_write       (ws_write),
        .br             (br)
    );

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_flow(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b exp %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_d2e(input d2e_t got, input d2e_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: ds_to_es_bus got %h exp %h", $time, got, exp);
            fail_run();
        end
    endtask

    // target only matters for a taken branch
    task automatic check_br(input br_req_t got, input br_req_t exp);
        if (got.stall !== exp.stall || got.taken !== exp.taken
            || (exp.taken && got.target !== exp.target)) begin
            $display("mismatch at %0t ns: br got %h exp %h", $time, got, exp);
            fail_run();
        end
    endtask

    function automatic reg_addr_t pick_reg();
        if ($urandom % 4 == 0) begin
            return 5'($urandom);
        end
        return 5'($urandom % 8);
    endfunction

    function automatic word_t rand_inst();
        word_t w;
        int    sel;
        w = $urandom;
        sel = int'($urandom % 40);
        w[14:10] = pick_reg();
        w[9:5] = pick_reg();
        w[4:0] = pick_reg();
        if (sel < 11) begin
            w[31:20] = 12'h001;
            w[19:15] = op5_3r[sel];
        end else if (sel < 14) begin
            w[31:20] = 12'h004;
            w[19:15] = op5_sh[sel-11];
        end else if (sel < 20) begin
            w[31:22] = {6'h00, op4_ri[sel-14]};
        end else if (sel == 20) begin
            w[31:25] = 7'b0001010;
        end else if (sel == 21) begin
            w[31:25] = 7'b0001110;
        end else if (sel < 30) begin
            w[31:22] = {6'h0a, op4_mem[sel-22]};
        end else if (sel < 39) begin
            // jirl, b, bl, beq .. bgeu are consecutive
            w[31:26] = 6'(sel - 30 + 'h13);
        end
        return w;
    endfunction

    function automatic exp_dec_t decode_model(input word_t w);
        exp_dec_t d;
        alu_op_t  a;
        word_t    si12;
        word_t    ui12;
        word_t    si20;
        d = '0;
        a = '0;
        si12 = {{20{w[21]}}, w[21:10]};
        ui12 = {20'b0, w[21:10]};
        si20 = {w[24:5], 12'b0};
        d.r1 = w[9:5];
        d.r2 = w[14:10];
        d.dest = w[4:0];
        d.offs = {{14{w[25]}}, w[25:10], 2'b0};
        case (w[31:26])
            6'h00: begin
                if (w[25:20] == 6'b000001) begin
                    case (w[19:15])
                        5'h00: a[alu_add] = 1'b1;
                        5'h02: a[alu_sub] = 1'b1;
                        5'h04: a[alu_slt] = 1'b1;
                        5'h05: a[alu_sltu] = 1'b1;
                        5'h08: a[alu_nor] = 1'b1;
                        5'h09: a[alu_and] = 1'b1;
                        5'h0a: a[alu_or] = 1'b1;
                        5'h0b: a[alu_xor] = 1'b1;
                        5'h0e: a[alu_sll] = 1'b1;
                        5'h0f: a[alu_srl] = 1'b1;
                        5'h10: a[alu_sra] = 1'b1;
                        default: a = '0;
                    endcase
                    d.need2 = (a != '0);
                end else if (w[25:20] == 6'b000100) begin
                    case (w[19:15])
                        5'h01: a[alu_sll] = 1'b1;
                        5'h09: a[alu_srl] = 1'b1;
                        5'h11: a[alu_sra] = 1'b1;
                        default: a = '0;
                    endcase
                    d.imm = {27'b0, w[14:10]};
                end else begin
                    case (w[25:22])
                        4'h8: a[alu_slt] = 1'b1;
                        4'h9: a[alu_sltu] = 1'b1;
                        4'ha: a[alu_add] = 1'b1;
                        4'hd: a[alu_and] = 1'b1;
                        4'he: a[alu_or] = 1'b1;
                        4'hf: a[alu_xor] = 1'b1;
                        default: a = '0;
                    endcase
                    d.imm = (w[25:22] >= 4'hd) ? ui12 : si12;
                end
                if (a != '0) begin
                    d.src2_imm = ~d.need2;
                    d.need1 = 1'b1;
                    d.rf_we = 1'b1;
                end else begin
                    d.imm = '0;
                end
            end
            6'h05, 6'h07: begin
                if (!w[25]) begin
                    a[alu_lui] = (w[31:26] == 6'h05);
                    a[alu_add] = (w[31:26] == 6'h07);
                    d.src1_pc = (w[31:26] == 6'h07);
                    d.src2_imm = 1'b1;
                    d.imm = si20;
                    d.rf_we = 1'b1;
                end
            end
            6'h0a: begin
                case (w[25:22])
                    4'h0: d.mem.ld_b = 1'b1;
                    4'h1: d.mem.ld_h = 1'b1;
                    4'h2: d.mem.ld_w = 1'b1;
                    4'h4: d.mem.st_b = 1'b1;
                    4'h5: d.mem.st_h = 1'b1;
                    4'h6: d.mem.st_w = 1'b1;
                    4'h8: d.mem.ld_bu = 1'b1;
                    4'h9: d.mem.ld_hu = 1'b1;
                    default: d.mem = '0;
                endcase
                if (d.mem != '0) begin
                    a[alu_add] = 1'b1;
                    d.src2_imm = 1'b1;
                    d.imm = si12;
                    d.need1 = 1'b1;
                    d.need2 = d.mem.st_b | d.mem.st_h | d.mem.st_w;
                    d.rf_we = ~d.need2;
                    d.r2 = d.need2 ? w[4:0] : w[14:10];
                end
            end
            6'h13, 6'h15: begin
                d.kind.jirl = (w[31:26] == 6'h13);
                d.kind.bl = (w[31:26] == 6'h15);
                a[alu_add] = 1'b1;
                d.src1_pc = 1'b1;
                d.src2_imm = 1'b1;
                d.imm = 32'd4;
                d.rf_we = 1'b1;
                d.need1 = d.kind.jirl;
                if (d.kind.bl) begin
                    d.dest = 5'd1;
                    d.offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
                end
            end
            6'h14: begin
                d.kind.b = 1'b1;
                d.offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                d.kind.beq = (w[31:26] == 6'h16);
                d.kind.bne = (w[31:26] == 6'h17);
                d.kind.blt = (w[31:26] == 6'h18);
                d.kind.bge = (w[31:26] == 6'h19);
                d.kind.bltu = (w[31:26] == 6'h1a);
                d.kind.bgeu = (w[31:26] == 6'h1b);
                d.need1 = 1'b1;
                d.need2 = 1'b1;
                d.r2 = w[4:0];
            end
            default: d.alu = '0;
        endcase
        d.alu = a;
        return d;
    endfunction

    function automatic logic es_hit(input reg_addr_t r);
        return es_fwd.we && r != '0 && r == es_fwd.waddr;
    endfunction

    // youngest producer first
    function automatic word_t operand(input reg_addr_t r);
        if (r == '0) begin
            return '0;
        end else if (es_hit(r)) begin
            return es_fwd.wdata;
        end else if (ms_fwd.we && ms_fwd.waddr == r) begin
            return ms_fwd.wdata;
        end else if (ws_write.we && ws_write.waddr == r) begin
            return ws_write.wdata;
        end
        return shadow[r];
    endfunction

    task automatic drive_random();
        fs_valid <= ($urandom % 8) != 0;
        fs_bus <= {$urandom & 32'hffff_fffc, rand_inst()};
        es_allowin <= ($urandom % 4) != 0;
        es_fwd <= {($urandom % 4) == 0, ($urandom % 2) == 0, pick_reg(), $urandom};
        ms_fwd <= {($urandom % 2) == 0, pick_reg(), $urandom};
        ws_write <= {($urandom % 2) == 0, pick_reg(), $urandom};
    endtask

    task automatic evaluate_cycle();
        exp_dec_t d;
        word_t    rj;
        word_t    rkd;
        logic     stall;
        logic     v_out;
        logic     allow;
        logic     cond;
        logic     taken;
        d2e_t     ed;
        br_req_t  eb;
        d = decode_model(m_inst);
        rj = operand(d.r1);
        rkd = operand(d.r2);
        stall = m_valid && es_fwd.res_from_mem
                && ((d.need1 && es_hit(d.r1)) || (d.need2 && es_hit(d.r2)));
        v_out = m_valid && !stall;
        allow = !m_valid || (!stall && es_allowin);
        cond = (d.kind.beq && rj == rkd) || (d.kind.bne && rj != rkd)
             || (d.kind.blt && $signed(rj) < $signed(rkd))
             || (d.kind.bge && $signed(rj) >= $signed(rkd))
             || (d.kind.bltu && rj < rkd) || (d.kind.bgeu && rj >= rkd)
             || d.kind.b || d.kind.bl || d.kind.jirl;
        taken = cond && v_out && es_allowin;
        check_flow(to_es_valid, v_out, "ds_to_es_valid");
        check_flow(ds_allowin, allow, "ds_allowin");
        eb.stall = stall && (d.kind != '0);
        eb.taken = taken;
        eb.target = d.kind.jirl ? rj + d.offs : m_pc + d.offs;
        check_br(br, eb);
        if (v_out) begin
            ed.alu_op = d.alu;
            ed.alu_src1 = d.src1_pc ? m_pc : rj;
            ed.alu_src2 = d.src2_imm ? d.imm : rkd;
            ed.res_from_mem = d.mem.ld_w | d.mem.ld_h | d.mem.ld_hu | d.mem.ld_b | d.mem.ld_bu;
            ed.mem_op = d.mem;
            ed.mem_en = d.mem.st_w | d.mem.st_h | d.mem.st_b;
            ed.rf_we = d.rf_we;
            ed.rf_waddr = d.dest;
            ed.rkd_value = rkd;
            ed.pc = m_pc;
            check_d2e(to_es_bus, ed);
        end
        if (v_out && es_allowin) begin
            emitted++;
        end
        if (taken) begin
            m_valid = 1'b0;
        end else if (allow) begin
            m_valid = fs_valid;
        end
        if (fs_valid && allow) begin
            m_pc = fs_bus.pc;
            m_inst = fs_bus.inst;
        end
        if (ws_write.we && ws_write.waddr != '0) begin
            shadow[ws_write.waddr] = ws_write.wdata;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles with %0d instructions out", cycles, emitted);
            fail_run();
        end
    end

    initial begin
        fs_valid = 1'b0;
        fs_bus = '0;
        es_allowin = 1'b0;
        es_fwd = '0;
        ms_fwd = '0;
        ws_write = '0;
        m_valid = 1'b0;
        m_pc = '0;
        m_inst = '0;
        emitted = 0;
        cycles = 0;
        shadow[0] = '0;
        wait (resetn === 1'b1);
        void'($urandom(32'h798));
        // fill the register file so every read is known
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            ws_write <= {1'b1, 5'(r), $urandom};
            @(negedge clk);
            shadow[r] = ws_write.wdata;
        end
        while (emitted < n_trans) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            evaluate_cycle();
        end
        $display("Verification passed");
        $finish;
    end

endmodule
